/* logic/copper_pkg.sv */
package copper_pkg;

    // Beam coordinate, same width for h and v
    typedef logic [10:0] coord_t;

    // Word address into the 2K program memory
    typedef logic [10:0] pc_t;

    // Opcode nibble at the top of the first word
    typedef enum logic [3:0] {
        INSN_WAIT  = 4'b0000,
        INSN_SKIP  = 4'b0010,
        INSN_JUMP  = 4'b0100,
        INSN_MOVER = 4'b1001,
        INSN_MOVEF = 4'b1010,
        INSN_MOVEP = 4'b1011,
        INSN_MOVEC = 4'b1100
    } opcode_t;

    // WAIT and SKIP flag bits
    localparam int FLAG_IGNORE_V = 0;
    localparam int FLAG_IGNORE_H = 1;

    // WAIT / SKIP layout
    typedef struct packed {
        opcode_t    opcode;
        logic       spare_y;
        coord_t     y;
        logic       spare_x;
        coord_t     x;
        logic [3:0] flags;
    } insn_pos_t;

    // MOVEx layout, the address is trimmed per opcode
    typedef struct packed {
        opcode_t     opcode;
        logic [11:0] addr;
        logic [15:0] data;
    } insn_move_t;

    // JMP layout, second word is ignored
    typedef struct packed {
        opcode_t     opcode;
        logic        spare;
        pc_t         target;
        logic [15:0] unused;
    } insn_jump_t;

    // One instruction, first word in the upper half
    typedef union packed {
        insn_pos_t  pos;
        insn_move_t move;
        insn_jump_t jump;
    } copper_insn_t;

    typedef struct packed {
        coord_t h;
        coord_t v;
    } beam_pos_t;

    // XR write payload
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
    } xr_wr_t;

    // Program memory write payload
    typedef struct packed {
        pc_t         addr;
        logic [15:0] data;
    } prog_wr_t;

    // Copper control register
    typedef struct packed {
        logic en;
        pc_t  init_pc;
    } copper_ctrl_t;

    // XR register number of the control register
    localparam logic [15:0] XR_COPP_CTRL = 16'h0001;

    // XR memory regions
    localparam logic [15:0] XR_TILE_MEM_BASE   = 16'h4000;
    localparam logic [15:0] XR_COLOR_MEM_BASE  = 16'h8000;
    localparam logic [15:0] XR_COPPER_MEM_BASE = 16'hA000;

endpackage

/* logic/copper_frame_ctrl.sv */
`timescale 1ns/1ps

module copper_frame_ctrl
    import copper_pkg::*;
#(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic         clk,
    input  logic         copp_reset,
    input  logic         host_reg_wr_i,
    input  logic [15:0]  host_reg_data_i,
    input  logic         xr_wr_i,
    input  xr_wr_t       xr_i,
    input  beam_pos_t    beam_i,
    output copper_ctrl_t ctrl_o,
    output logic         frame_restart_o
);

    // Restart point, a few pixels before the frame wraps
    localparam coord_t RESTART_H = coord_t'(H_TOTAL - 5);
    localparam coord_t RESTART_V = coord_t'(V_TOTAL - 1);

    logic        copp_ctrl_wr;
    logic        ctrl_load;
    logic [15:0] ctrl_word;
    logic        at_restart;

    // The copper writing its own control register via MOVER
    assign copp_ctrl_wr = xr_wr_i && (xr_i.addr == XR_COPP_CTRL);
    assign ctrl_load    = host_reg_wr_i || copp_ctrl_wr;

    // Host takes priority on a same-cycle collision
    assign ctrl_word = host_reg_wr_i ? host_reg_data_i : xr_i.data;

    assign at_restart = (beam_i.h == RESTART_H) && (beam_i.v == RESTART_V);

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ctrl_o          <= '0;
            frame_restart_o <= 1'b0;
        end else begin
            if (ctrl_load) begin
                // Bit 15 enable, bits 10:0 initial PC
                ctrl_o.en      <= ctrl_word[15];
                ctrl_o.init_pc <= ctrl_word[10:0];
            end
            // One cycle pulse, the beam only sits there for one pixel
            frame_restart_o <= at_restart;
        end
    end

endmodule

/* logic/copper_prog_ram.sv */
`timescale 1ns/1ps

module copper_prog_ram
    import copper_pkg::*;
(
    input  logic        clk,
    input  logic        host_prog_wr_i,
    input  prog_wr_t    host_prog_i,
    input  logic        prog_wr_i,
    input  prog_wr_t    prog_i,
    input  logic        rd_en_i,
    input  pc_t         rd_addr_i,
    output logic [15:0] rd_data_o
);

    // One word per program address
    localparam int DEPTH = 2 ** $bits(pc_t);

    logic [15:0] mem [DEPTH];

    logic        wr_en;
    prog_wr_t    wr;

    // Host write wins, a colliding MOVEC is dropped
    always_comb begin
        wr_en = host_prog_wr_i || prog_wr_i;
        wr    = host_prog_wr_i ? host_prog_i : prog_i;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read, data is valid the cycle after rd_en
    // Read of an address being written returns the old word
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* logic/copper_sequencer.sv */
`timescale 1ns/1ps

module copper_sequencer
    import copper_pkg::*;
(
    input  logic         clk,
    input  logic         copp_reset,
    input  copper_ctrl_t ctrl_i,
    input  logic         frame_restart_i,
    input  beam_pos_t    beam_i,
    input  logic [15:0]  rd_data_i,
    output logic         rd_en_o,
    output pc_t          rd_addr_o,
    output logic         exec_move_o,
    output copper_insn_t insn_o
);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_FETCH,
        ST_LATCH,
        ST_EXEC,
        ST_EX_WAIT,
        ST_EX_SKIP
    } seq_state_t;

    seq_state_t   state;
    pc_t          pc;
    copper_insn_t insn;

    // Set while the second word of the pair is being fetched
    logic         second_word;

    // Position compares, registered at EXEC
    logic         v_reached;
    logic         h_reached;

    logic         pos_hit;
    logic         ignore_both;
    logic         is_move;

    always_comb begin
        // An ignored coordinate always counts as reached
        pos_hit = (insn.pos.flags[FLAG_IGNORE_V] || v_reached) &&
                  (insn.pos.flags[FLAG_IGNORE_H] || h_reached);
        ignore_both = insn.pos.flags[FLAG_IGNORE_V] && insn.pos.flags[FLAG_IGNORE_H];
        is_move = insn.move.opcode inside {INSN_MOVER, INSN_MOVEF, INSN_MOVEP, INSN_MOVEC};
    end

    // Memory address follows the PC directly
    assign rd_en_o   = (state == ST_FETCH) && ctrl_i.en;
    assign rd_addr_o = pc;
    assign insn_o    = insn;

    // MOVE request, dropped if the frame restarts or the copper is stopped
    assign exec_move_o = (state == ST_EXEC) && is_move && ctrl_i.en && !frame_restart_i;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state       <= ST_INIT;
            pc          <= '0;
            second_word <= 1'b0;
        end else if (frame_restart_i) begin
            // Abort whatever is running and restart from the initial PC
            state       <= ST_INIT;
            pc          <= ctrl_i.init_pc;
            second_word <= 1'b0;
        end else if (!ctrl_i.en) begin
            // Idle copper tracks the initial PC, so enable starts there
            state       <= ST_INIT;
            pc          <= ctrl_i.init_pc;
            second_word <= 1'b0;
        end else begin
            case (state)
                // First instruction only, costs the extra cycle
                ST_INIT: begin
                    state <= ST_FETCH;
                end
                // Two back to back word reads, PC ends on the second word
                ST_FETCH: begin
                    if (!second_word) begin
                        pc          <= pc + pc_t'(1);
                        second_word <= 1'b1;
                    end else begin
                        second_word <= 1'b0;
                        state       <= ST_LATCH;
                    end
                end
                // Second word arrives here
                ST_LATCH: begin
                    state <= ST_EXEC;
                end
                ST_EXEC: begin
                    case (insn.move.opcode)
                        // Compare now, decide next cycle
                        INSN_WAIT: begin
                            state <= ST_EX_WAIT;
                        end
                        INSN_SKIP: begin
                            state <= ST_EX_SKIP;
                        end
                        INSN_JUMP: begin
                            pc    <= insn.jump.target;
                            state <= ST_FETCH;
                        end
                        // MOVEs are handed to the move unit, illegal ops fall through too
                        default: begin
                            pc    <= pc + pc_t'(1);
                            state <= ST_FETCH;
                        end
                    endcase
                end
                ST_EX_WAIT: begin
                    // Both flags set never matches, only a restart gets out
                    if (pos_hit && !ignore_both) begin
                        pc    <= pc + pc_t'(1);
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_EXEC;
                    end
                end
                ST_EX_SKIP: begin
                    // +3 steps over the following two-word instruction
                    if (pos_hit) begin
                        pc <= pc + pc_t'(3);
                    end else begin
                        pc <= pc + pc_t'(1);
                    end
                    state <= ST_FETCH;
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

    // Instruction and compare results
    always_ff @(posedge clk) begin
        // First word returns while the second word is being read
        if (state == ST_FETCH && second_word) begin
            insn[31:16] <= rd_data_i;
        end
        if (state == ST_LATCH) begin
            insn[15:0] <= rd_data_i;
        end
        // Reached means at or past the target
        if (state == ST_EXEC) begin
            v_reached <= beam_i.v >= insn.pos.y;
            h_reached <= beam_i.h >= insn.pos.x;
        end
    end

endmodule

/* logic/copper_move_unit.sv */
`timescale 1ns/1ps

module copper_move_unit
    import copper_pkg::*;
(
    input  logic         clk,
    input  logic         copp_reset,
    input  logic         exec_move_i,
    input  copper_insn_t insn_i,
    output logic         xr_wr_o,
    output xr_wr_t       xr_o,
    output logic         prog_wr_o,
    output prog_wr_t     prog_o
);

    logic   is_move;
    logic   is_movec;
    xr_wr_t xr_next;

    // Address formed from the region base and the opcode's address bits
    always_comb begin
        is_move      = 1'b1;
        is_movec     = 1'b0;
        xr_next.addr = '0;
        xr_next.data = insn_i.move.data;
        case (insn_i.move.opcode)
            // XR registers sit at base 0
            INSN_MOVER: begin
                xr_next.addr = {8'h00, insn_i.move.addr[7:0]};
            end
            INSN_MOVEF: begin
                xr_next.addr = {XR_TILE_MEM_BASE[15:12], insn_i.move.addr[11:0]};
            end
            INSN_MOVEP: begin
                xr_next.addr = {XR_COLOR_MEM_BASE[15:8], insn_i.move.addr[7:0]};
            end
            // Also lands in the copper's own program memory
            INSN_MOVEC: begin
                xr_next.addr = {XR_COPPER_MEM_BASE[15:11], insn_i.move.addr[10:0]};
                is_movec     = 1'b1;
            end
            // Illegal opcode, no write
            default: begin
                is_move = 1'b0;
            end
        endcase
    end

    // Single cycle strobes, one cycle behind EXEC
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_o   <= 1'b0;
            prog_wr_o <= 1'b0;
        end else begin
            xr_wr_o   <= exec_move_i && is_move;
            prog_wr_o <= exec_move_i && is_movec;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_move_i) begin
            xr_o        <= xr_next;
            prog_o.addr <= insn_i.move.addr[10:0];
            prog_o.data <= insn_i.move.data;
        end
    end

endmodule

/* logic/copper_top.sv */
`timescale 1ns/1ps

module copper_top
    import copper_pkg::*;
#(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic        clk,
    input  logic        copp_reset,
    input  logic        host_reg_wr_i,
    input  logic [15:0] host_reg_data_i,
    input  logic        host_prog_wr_i,
    input  prog_wr_t    host_prog_i,
    input  beam_pos_t   beam_i,
    output logic        xr_wr_o,
    output xr_wr_t      xr_o
);

    copper_ctrl_t ctrl;
    logic         frame_restart;

    // Fetch path
    logic         rd_en;
    pc_t          rd_addr;
    logic [15:0]  rd_data;

    // Execute path
    logic         exec_move;
    copper_insn_t insn;

    // MOVEC write back into program memory
    logic         prog_wr;
    prog_wr_t     prog;

    // Watches the copper's own XR writes for the control register
    copper_frame_ctrl #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_frame_ctrl (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .host_reg_wr_i   (host_reg_wr_i),
        .host_reg_data_i (host_reg_data_i),
        .xr_wr_i         (xr_wr_o),
        .xr_i            (xr_o),
        .beam_i          (beam_i),
        .ctrl_o          (ctrl),
        .frame_restart_o (frame_restart)
    );

    copper_prog_ram u_prog_ram (
        .clk            (clk),
        .host_prog_wr_i (host_prog_wr_i),
        .host_prog_i    (host_prog_i),
        .prog_wr_i      (prog_wr),
        .prog_i         (prog),
        .rd_en_i        (rd_en),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data)
    );

    copper_sequencer u_sequencer (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .ctrl_i          (ctrl),
        .frame_restart_i (frame_restart),
        .beam_i          (beam_i),
        .rd_data_i       (rd_data),
        .rd_en_o         (rd_en),
        .rd_addr_o       (rd_addr),
        .exec_move_o     (exec_move),
        .insn_o          (insn)
    );

    copper_move_unit u_move_unit (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .exec_move_i (exec_move),
        .insn_i      (insn),
        .xr_wr_o     (xr_wr_o),
        .xr_o        (xr_o),
        .prog_wr_o   (prog_wr),
        .prog_o      (prog)
    );

endmodule

/* bench/copper_properties.sv */
`timescale 1ns/1ps

module copper_properties (
    input logic clk,
    input logic copp_reset,
    input logic xr_wr,
    input logic prog_wr,
    input logic rd_en,
    input logic exec_move
);

    // Strobes never last longer than one cycle
    assert property (@(posedge clk) disable iff (copp_reset) xr_wr |=> !xr_wr)
        else $error("xr_wr_o wider than one cycle");

    assert property (@(posedge clk) disable iff (copp_reset) prog_wr |=> !prog_wr)
        else $error("prog_wr wider than one cycle");

    // Everything quiet in the first cycle out of reset
    assert property (@(posedge clk) $past(copp_reset) |-> !xr_wr && !prog_wr && !rd_en)
        else $error("strobe active right after reset");

    // An XR write is always the registered result of exec_move
    assert property (@(posedge clk) disable iff (copp_reset) $rose(xr_wr) |-> $past(exec_move))
        else $error("xr_wr_o rose without exec_move");

endmodule

bind copper_top copper_properties u_properties (
    .clk       (clk),
    .copp_reset(copp_reset),
    .xr_wr     (xr_wr_o),
    .prog_wr   (prog_wr),
    .rd_en     (rd_en),
    .exec_move (exec_move)
);

/* bench/copper_tb.sv */
`timescale 1ns/1ps

module copper_tb
    import copper_pkg::*;
;

    localparam int H_TOTAL = 64;
    localparam int V_TOTAL = 16;

    logic        clk;
    logic        copp_reset;
    logic        host_reg_wr_i;
    logic [15:0] host_reg_data_i;
    logic        host_prog_wr_i;
    prog_wr_t    host_prog_i;
    beam_pos_t   beam;
    logic        xr_wr_o;
    xr_wr_t      xr_o;

    // Expected XR writes and the beam condition that must hold for each
    xr_wr_t      exp_q[$];
    logic [3:0]  cond_flags_q[$];
    coord_t      cond_y_q[$];
    coord_t      cond_x_q[$];

    string       test_name;
    logic [31:0] rng_state;
    pc_t         load_pc;

    copper_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) UUT (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .host_reg_wr_i   (host_reg_wr_i),
        .host_reg_data_i (host_reg_data_i),
        .host_prog_wr_i  (host_prog_wr_i),
        .host_prog_i     (host_prog_i),
        .beam_i          (beam),
        .xr_wr_o         (xr_wr_o),
        .xr_o            (xr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Beam model counts h along each line and steps v at the end of the line
    always @(posedge clk) begin
        if (beam.h == coord_t'(H_TOTAL - 1)) begin
            beam.h <= '0;
            beam.v <= (beam.v == coord_t'(V_TOTAL - 1)) ? '0 : beam.v + coord_t'(1);
        end else begin
            beam.h <= beam.h + coord_t'(1);
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            fail_run("a checked value did not match");
        end
    endtask

    // Xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Reference model of a MOVE from the region base and the trimmed address bits
    function automatic xr_wr_t expected_xr(input logic [31:0] insn);
        xr_wr_t      w;
        logic [11:0] a;
        a      = insn[27:16];
        w.data = insn[15:0];
        w.addr = '0;
        case (insn[31:28])
            INSN_MOVER: w.addr = {8'h00, a[7:0]};
            INSN_MOVEF: w.addr = {XR_TILE_MEM_BASE[15:12], a};
            INSN_MOVEP: w.addr = {XR_COLOR_MEM_BASE[15:8], a[7:0]};
            INSN_MOVEC: w.addr = {XR_COPPER_MEM_BASE[15:11], a[10:0]};
            default:    w.addr = '0;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] pos_insn(input opcode_t op, input coord_t y,
                                             input coord_t x, input logic [3:0] flags);
        return {op, 1'b0, y, 1'b0, x, flags};
    endfunction

    function automatic logic [31:0] move_insn(input logic [3:0] op, input logic [11:0] addr,
                                              input logic [15:0] data);
        return {op, addr, data};
    endfunction

    function automatic logic [31:0] jump_insn(input pc_t target);
        return {INSN_JUMP, 1'b0, target, 16'h0000};
    endfunction

    task automatic write_prog_word(input pc_t addr, input logic [15:0] data);
        @(posedge clk);
        host_prog_wr_i   <= 1'b1;
        host_prog_i.addr <= addr;
        host_prog_i.data <= data;
        @(posedge clk);
        host_prog_wr_i   <= 1'b0;
    endtask

    // Two words per instruction with the upper half first
    task automatic emit(input logic [31:0] insn);
        write_prog_word(load_pc, insn[31:16]);
        write_prog_word(load_pc + pc_t'(1), insn[15:0]);
        load_pc = load_pc + pc_t'(2);
    endtask

    // Flags 4'b0011 means no beam condition on the write
    task automatic expect_move(input logic [31:0] insn, input logic [3:0] flags,
                               input coord_t y, input coord_t x);
        exp_q.push_back(expected_xr(insn));
        cond_flags_q.push_back(flags);
        cond_y_q.push_back(y);
        cond_x_q.push_back(x);
    endtask

    task automatic set_ctrl(input logic [15:0] word);
        @(posedge clk);
        host_reg_wr_i   <= 1'b1;
        host_reg_data_i <= word;
        @(posedge clk);
        host_reg_wr_i   <= 1'b0;
    endtask

    task automatic wait_beam(input coord_t v, input coord_t h);
        int n;
        n = 0;
        while (!(beam.v == v && beam.h == h)) begin
            @(posedge clk);
            n++;
            if (n > 2 * H_TOTAL * V_TOTAL) fail_run("timeout waiting for beam position");
        end
    endtask

    task automatic wait_queue_empty(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > max_cycles) fail_run("timeout waiting for expected XR writes");
        end
    endtask

    // Initial PC settles while disabled and the copper is enabled at frame start
    task automatic start_program(input pc_t init);
        set_ctrl({5'b0, init});
        wait_beam(coord_t'(0), coord_t'(0));
        set_ctrl({1'b1, 4'b0, init});
    endtask

    task automatic finish_program();
        wait_queue_empty(2 * H_TOTAL * V_TOTAL);
        repeat (20) @(posedge clk);
        set_ctrl(16'h0000);
    endtask

    // Compare process samples the outputs on the falling edge
    initial begin
        xr_wr_t e;
        logic   ok;
        forever begin
            @(negedge clk);
            if (!copp_reset && xr_wr_o) begin
                if (exp_q.size() == 0) begin
                    fail_run("XR write seen with no write expected");
                end else begin
                    e  = exp_q.pop_front();
                    ok = (cond_flags_q[0][FLAG_IGNORE_V] || beam.v >= cond_y_q[0]) &&
                         (cond_flags_q[0][FLAG_IGNORE_H] || beam.h >= cond_x_q[0]);
                    void'(cond_flags_q.pop_front());
                    void'(cond_y_q.pop_front());
                    void'(cond_x_q.pop_front());
                    check_value(test_name, e, xr_o);
                    check_value({test_name, " position"}, 32'd1, {31'b0, ok});
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] insn;
        logic [31:0] target_mover;
        logic [3:0]  op;
        logic [11:0] addr;
        host_reg_wr_i   <= 1'b0;
        host_reg_data_i <= '0;
        host_prog_wr_i  <= 1'b0;
        host_prog_i     <= '0;
        beam            <= '0;
        copp_reset      <= 1'b1;
        rng_state = 32'd24097;
        test_name = "reset";
        repeat (8) @(posedge clk);
        copp_reset <= 1'b0;

        // Random moves with illegal opcodes mixed in
        test_name = "random moves";
        load_pc = '0;
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            case (r[1:0])
                2'd0: op = INSN_MOVER;
                2'd1: op = INSN_MOVEF;
                2'd2: op = INSN_MOVEP;
                default: op = INSN_MOVEC;
            endcase
            // Keep MOVER off the control register and MOVEC far above the program
            if (op == INSN_MOVER) addr = {4'h0, 4'h2, r[11:8]};
            else if (op == INSN_MOVEC) addr = {4'h7, r[11:4]};
            else addr = r[15:4];
            insn = move_insn(op, addr, 16'(next_rand()));
            emit(insn);
            expect_move(insn, 4'b0011, '0, '0);
            if (i % 4 == 3) emit(move_insn(4'hE, r[27:16], r[31:16]));
        end
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        start_program('0);
        finish_program();

        // WAIT on h only, v only and then both
        test_name = "wait";
        load_pc = '0;
        emit(pos_insn(INSN_WAIT, '0, coord_t'(30), 4'b0001));
        insn = move_insn(INSN_MOVER, 12'h020, 16'h1111);
        emit(insn);
        expect_move(insn, 4'b0001, '0, coord_t'(30));
        emit(pos_insn(INSN_WAIT, coord_t'(6), '0, 4'b0010));
        insn = move_insn(INSN_MOVER, 12'h021, 16'h2222);
        emit(insn);
        expect_move(insn, 4'b0010, coord_t'(6), '0);
        emit(pos_insn(INSN_WAIT, coord_t'(9), coord_t'(20), 4'b0000));
        insn = move_insn(INSN_MOVER, 12'h022, 16'h3333);
        emit(insn);
        expect_move(insn, 4'b0000, coord_t'(9), coord_t'(20));
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        start_program('0);
        finish_program();

        // SKIP taken when reached and not taken before the target line
        test_name = "skip";
        load_pc = '0;
        emit(pos_insn(INSN_SKIP, '0, '0, 4'b0000));
        emit(move_insn(INSN_MOVER, 12'h030, 16'hDEAD));
        insn = move_insn(INSN_MOVER, 12'h031, 16'h4444);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        emit(pos_insn(INSN_SKIP, coord_t'(14), '0, 4'b0010));
        insn = move_insn(INSN_MOVER, 12'h032, 16'h5555);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        start_program('0);
        finish_program();

        // JMP over a block and then a MOVEC patches the data word at address 13
        test_name = "jump and movec";
        load_pc = '0;
        emit(jump_insn(pc_t'(8)));
        for (int i = 0; i < 3; i++) emit(move_insn(INSN_MOVEF, 12'h100, 16'hBAD0));
        insn = move_insn(INSN_MOVEC, 12'd13, 16'h7777);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        insn = move_insn(INSN_MOVEP, 12'h005, 16'h6666);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        target_mover = move_insn(INSN_MOVER, 12'h040, 16'h0BAD);
        emit(target_mover);
        expect_move({target_mover[31:16], 16'h7777}, 4'b0011, '0, '0);
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        start_program('0);
        finish_program();

        // Frame restart repeats the program from the initial PC
        test_name = "frame restart";
        load_pc = pc_t'(11'h040);
        emit(move_insn(INSN_MOVER, 12'h050, 16'hA1A1));
        emit(move_insn(INSN_MOVER, 12'h051, 16'hB2B2));
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        for (int f = 0; f < 3; f++) begin
            expect_move(move_insn(INSN_MOVER, 12'h050, 16'hA1A1), 4'b0011, '0, '0);
            expect_move(move_insn(INSN_MOVER, 12'h051, 16'hB2B2), 4'b0011, '0, '0);
            if (f == 0) start_program(pc_t'(11'h040));
            wait_queue_empty(2 * H_TOTAL * V_TOTAL);
            // The restart lands just before the wrap, so each pass ends in the first line
            check_value({test_name, " line"}, 32'd0, {21'b0, beam.v});
        end
        set_ctrl(16'h0040);

        // Copper clears its own enable and nothing may follow
        test_name = "self disable";
        load_pc = pc_t'(11'h040);
        insn = move_insn(INSN_MOVER, 12'h052, 16'hC3C3);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        insn = move_insn(INSN_MOVER, XR_COPP_CTRL[11:0], 16'h0040);
        emit(insn);
        expect_move(insn, 4'b0011, '0, '0);
        emit(move_insn(INSN_MOVER, 12'h053, 16'hD4D4));
        emit(pos_insn(INSN_WAIT, '0, '0, 4'b0011));
        start_program(pc_t'(11'h040));
        wait_queue_empty(2 * H_TOTAL * V_TOTAL);
        repeat (2 * H_TOTAL * V_TOTAL) @(posedge clk);

        if (exp_q.size() != 0) begin
            fail_run("expected XR writes still pending at the end");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* src.f */
logic/copper_pkg.sv
logic/copper_frame_ctrl.sv
logic/copper_prog_ram.sv
logic/copper_sequencer.sv
logic/copper_move_unit.sv
logic/copper_top.sv
bench/copper_properties.sv
bench/copper_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module copper_tb \
    -o copper_sim

./obj_dir/copper_sim
